/* all.f */
+incdir+hw
hw/issue_pkg.sv
hw/issue_enqueue.sv
hw/issue_bank.sv
hw/issue_select.sv
hw/issue_operand.sv
hw/issue_top.sv
tb/issue_tb.sv

/* hw/issue_bank.sv */
`include "issue_macros.svh"

module issue_bank (
    input  logic            clk,
    input  logic            we,
    input  issue_pkg::ptr_t waddr,
    input  issue_pkg::ptr_t raddr,
    input  issue_pkg::uop_t wdata,
    output issue_pkg::uop_t rdata
);
    import issue_pkg::*;

    // plain storage, entry valid bits are only meaningful
    // between head and tail
    uop_t mem [`ISSUE_QUEUE_DEPTH];

    // write at the tail
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // head entry visible in the same cycle
    // so a write at edge N is a candidate from cycle N+1
    assign rdata = mem[raddr];

endmodule

/* hw/issue_enqueue.sv */
`include "issue_macros.svh"

module issue_enqueue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  issue_pkg::uop_t [`ISSUE_LANES-1:0] in_uop,
    output logic                                we_even,
    output logic                                we_odd,
    output issue_pkg::uop_t                     wdata_even,
    output issue_pkg::uop_t                     wdata_odd,
    output issue_pkg::ptr_t                     tail_even,
    output issue_pkg::ptr_t                     tail_odd
);
    import issue_pkg::*;

    // equal tails mean odd bank takes the next entry
    logic odd_first;
    ptr_t tail_even_q;
    ptr_t tail_odd_q;

    assign odd_first = (tail_odd_q == tail_even_q);

    // lane 0 is the older one and always the first valid lane
    // so it lands in whichever bank is next, lane 1 in the other
    always_comb begin
        if (odd_first) begin
            wdata_odd  = in_uop[0];
            wdata_even = in_uop[1];
        end else begin
            wdata_even = in_uop[0];
            wdata_odd  = in_uop[1];
        end
        // incoming ops are dropped in the flush cycle
        we_odd  = wdata_odd.valid && !flush;
        we_even = wdata_even.valid && !flush;
    end

    // one step per write, pointers wrap at the bank depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail_even_q <= '0;
            tail_odd_q  <= '0;
        end else begin
            if (we_even) begin
                tail_even_q <= tail_even_q + ptr_t'(1);
            end
            if (we_odd) begin
                tail_odd_q <= tail_odd_q + ptr_t'(1);
            end
        end
    end

    assign tail_even = tail_even_q;
    assign tail_odd  = tail_odd_q;

    // decode packs valid lanes from lane 0 upward
    // the steering above relies on it
    a_lane_packed: assert property (
        @(posedge clk) disable iff (rst)
        !(in_uop[1].valid && !in_uop[0].valid)
    ) else $error("lane 1 valid while lane 0 empty");

endmodule

/* hw/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// entries held by each of the two banks
`define ISSUE_QUEUE_DEPTH 16

// bank pointer width, log2 of the depth
`define ISSUE_PTR_W 4

// general register number width
`define ISSUE_REG_W 5

// operand and pc width
`define ISSUE_DATA_W 32

// micro-ops accepted and issued per cycle
`define ISSUE_LANES 2

// credits held by decode after reset or flush
// two entries short of both banks full, so neither bank can pass 15
`define ISSUE_CREDITS 30

`endif

/* hw/issue_operand.sv */
`include "issue_macros.svh"

module issue_operand (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  issue_pkg::cand_t                       cand,
    input  issue_pkg::word_t [2*`ISSUE_LANES-1:0] rf_data,
    input  issue_pkg::src_t  [2*`ISSUE_LANES-1:0] src,
    output issue_pkg::issued_t [`ISSUE_LANES-1:0] out_uop
);
    import issue_pkg::*;

    issued_t nxt_older;
    issued_t nxt_younger;

    // bypass value wins over the register file read
    function automatic word_t pick(input src_t s, input word_t rf);
        return s.hit ? s.data : rf;
    endfunction

    // older goes to lane 0, younger to lane 1
    always_comb begin
        nxt_older         = '0;
        nxt_younger       = '0;
        if (cand.issue_older) begin
            nxt_older.uop = cand.older;
            nxt_older.rd1 = pick(src[0], rf_data[0]);
            nxt_older.rd2 = pick(src[1], rf_data[1]);
        end
        if (cand.issue_younger) begin
            nxt_younger.uop     = cand.younger;
            nxt_younger.rd1     = pick(src[2], rf_data[2]);
            nxt_younger.rd2     = pick(src[3], rf_data[3]);
            // paired with a branch means it is the delay slot
            nxt_younger.is_slot = (cand.older.op_class == OP_BRANCH);
        end
    end

    // pipeline register toward execute, no stall from downstream
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_uop <= '0;
        end else begin
            out_uop[0] <= nxt_older;
            out_uop[1] <= nxt_younger;
        end
    end

    // slot tag only on a live lane 1 that sits behind a branch in lane 0
    a_slot_valid: assert property (
        @(posedge clk) disable iff (rst)
        !out_uop[0].is_slot &&
        (!out_uop[1].is_slot ||
         (out_uop[1].uop.valid && out_uop[0].uop.op_class == OP_BRANCH))
    ) else $error("is_slot on invalid or unpaired lane");

endmodule

/* hw/issue_pkg.sv */
`include "issue_macros.svh"

package issue_pkg;

    // general register number
    typedef logic [`ISSUE_REG_W-1:0] reg_addr_t;

    // operand value, also used for pc and imm
    typedef logic [`ISSUE_DATA_W-1:0] word_t;

    // read or write pointer into one bank
    typedef logic [`ISSUE_PTR_W-1:0] ptr_t;

    // coarse class, enough for the pairing checks
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_MULDIV = 3'd1,
        OP_BRANCH = 3'd2,
        OP_MFHI   = 3'd3,
        OP_MFLO   = 3'd4,
        OP_MTHI   = 3'd5,
        OP_MTLO   = 3'd6
    } op_class_t;

    // decoded micro-op as handed over by decode
    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_class_t op_class;
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t rdst;
        logic      regwrite;
        word_t     imm;
    } uop_t;

    // per source status from the bypass network
    typedef struct packed {
        logic  ready;
        logic  hit;
        word_t data;
    } src_t;

    // one lane toward execute
    typedef struct packed {
        uop_t  uop;
        word_t rd1;
        word_t rd2;
        logic  is_slot;
    } issued_t;

    // oldest two entries and the issue decision for them
    typedef struct packed {
        uop_t older;
        uop_t younger;
        logic issue_older;
        logic issue_younger;
    } cand_t;

endpackage

/* hw/issue_select.sv */
`include "issue_macros.svh"

module issue_select (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  flush,
    input  issue_pkg::uop_t                       rdata_even,
    input  issue_pkg::uop_t                       rdata_odd,
    input  issue_pkg::ptr_t                       tail_even,
    input  issue_pkg::ptr_t                       tail_odd,
    input  issue_pkg::src_t [2*`ISSUE_LANES-1:0] src,
    output issue_pkg::cand_t                      cand,
    output issue_pkg::ptr_t                       head_even,
    output issue_pkg::ptr_t                       head_odd,
    output logic [1:0]                            credit_return
);
    import issue_pkg::*;

    ptr_t head_even_q;
    ptr_t head_odd_q;
    ptr_t fill_even;
    ptr_t fill_odd;
    logic odd_older;
    logic even_empty;
    logic odd_empty;
    uop_t older;
    uop_t younger;
    logic older_ready;
    logic younger_ready;
    logic older_branch;
    logic raw_hazard;
    logic pair_hazard;
    logic younger_ok;
    logic issue_older;
    logic issue_younger;
    logic adv_even;
    logic adv_odd;

    // equal heads, odd entry was written first
    assign odd_older  = (head_odd_q == head_even_q);
    assign even_empty = (head_even_q == tail_even);
    assign odd_empty  = (head_odd_q == tail_odd);

    // entries held per bank
    assign fill_even = tail_even - head_even_q;
    assign fill_odd  = tail_odd - head_odd_q;

    // an empty bank offers no candidate
    always_comb begin
        older   = '0;
        younger = '0;
        if (odd_older) begin
            if (!odd_empty) begin
                older = rdata_odd;
            end
            if (!even_empty) begin
                younger = rdata_even;
            end
        end else begin
            if (!even_empty) begin
                older = rdata_even;
            end
            if (!odd_empty) begin
                younger = rdata_odd;
            end
        end
    end

    // src 0,1 belong to the older, src 2,3 to the younger
    assign older_ready   = src[0].ready && src[1].ready;
    assign younger_ready = src[2].ready && src[3].ready;
    assign older_branch  = (older.op_class == OP_BRANCH);

    // delay slot may read the branch result, so raw is waived there
    assign raw_hazard = older.regwrite && !older_branch &&
                        ((older.rdst == younger.ra1) || (older.rdst == younger.ra2));

    // remaining pair rules
    // one muldiv unit, no branch in lane 1, hi/lo written then read
    assign pair_hazard = raw_hazard ||
        ((older.op_class == OP_MULDIV) && (younger.op_class == OP_MULDIV)) ||
        (younger.op_class == OP_BRANCH) ||
        ((older.op_class == OP_MTHI) && (younger.op_class == OP_MFHI)) ||
        ((older.op_class == OP_MTLO) && (younger.op_class == OP_MFLO));

    assign younger_ok = younger.valid && younger_ready && !pair_hazard;

    // branch waits until its slot can go with it
    assign issue_older   = older.valid && older_ready && !(older_branch && !younger_ok);
    assign issue_younger = issue_older && younger_ok;

    always_comb begin
        cand.older         = older;
        cand.younger       = younger;
        cand.issue_older   = issue_older;
        cand.issue_younger = issue_younger;
    end

    // which bank each issued op came from
    assign adv_odd  = odd_older ? issue_older : issue_younger;
    assign adv_even = odd_older ? issue_younger : issue_older;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_even_q   <= '0;
            head_odd_q    <= '0;
            credit_return <= '0;
        end else begin
            if (adv_even) begin
                head_even_q <= head_even_q + ptr_t'(1);
            end
            if (adv_odd) begin
                head_odd_q <= head_odd_q + ptr_t'(1);
            end
            // entries freed at this edge go back to decode next cycle
            credit_return <= {1'b0, issue_older} + {1'b0, issue_younger};
        end
    end

    assign head_even = head_even_q;
    assign head_odd  = head_odd_q;

    // odd head leads the even head by at most one
    // a lone younger would leave one head out of step with the other
    a_no_lone_younger: assert property (
        @(posedge clk) disable iff (rst)
        ptr_t'(head_odd_q - head_even_q) <= ptr_t'(1)
    ) else $error("younger issued without older");

    // odd bank holds as many entries as the even bank or one more while it is older
    // a head that ran past its tail breaks that balance
    a_head_behind_tail: assert property (
        @(posedge clk) disable iff (rst)
        (odd_older ? ptr_t'(fill_odd - fill_even) : ptr_t'(fill_even - fill_odd))
            <= ptr_t'(1)
    ) else $error("head passed tail");

endmodule

/* hw/issue_top.sv */
`include "issue_macros.svh"

module issue_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    input  issue_pkg::uop_t    [`ISSUE_LANES-1:0]   in_uop,
    output logic [1:0]                               credit_return,
    output issue_pkg::reg_addr_t [2*`ISSUE_LANES-1:0] rs_addr,
    input  issue_pkg::word_t   [2*`ISSUE_LANES-1:0] rf_data,
    input  issue_pkg::src_t    [2*`ISSUE_LANES-1:0] src,
    output issue_pkg::issued_t [`ISSUE_LANES-1:0]   out_uop
);
    import issue_pkg::*;

    logic  we_even;
    logic  we_odd;
    uop_t  wdata_even;
    uop_t  wdata_odd;
    uop_t  rdata_even;
    uop_t  rdata_odd;
    ptr_t  tail_even;
    ptr_t  tail_odd;
    ptr_t  head_even;
    ptr_t  head_odd;
    cand_t cand;

    // steering and tails
    issue_enqueue u_enqueue (
        .clk, .rst, .flush, .in_uop,
        .we_even, .we_odd, .wdata_even, .wdata_odd,
        .tail_even, .tail_odd
    );

    issue_bank bank_even (
        .clk, .we(we_even), .waddr(tail_even), .raddr(head_even),
        .wdata(wdata_even), .rdata(rdata_even)
    );

    issue_bank bank_odd (
        .clk, .we(we_odd), .waddr(tail_odd), .raddr(head_odd),
        .wdata(wdata_odd), .rdata(rdata_odd)
    );

    // ordering, pairing, heads and credits
    issue_select u_select (
        .clk, .rst, .flush, .rdata_even, .rdata_odd,
        .tail_even, .tail_odd, .src, .cand,
        .head_even, .head_odd, .credit_return
    );

    issue_operand u_operand (
        .clk, .rst, .flush, .cand, .rf_data, .src, .out_uop
    );

    // register file read addresses follow the candidates
    assign rs_addr[0] = cand.older.ra1;
    assign rs_addr[1] = cand.older.ra2;
    assign rs_addr[2] = cand.younger.ra1;
    assign rs_addr[3] = cand.younger.ra2;

endmodule

/* run.sh */
#!/bin/sh
# build and run the issue queue testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb -f all.f -o issue_sim \
    && ./obj_dir/issue_sim \
    || exit 1

/* tb/issue_golden.txt */
# T name | U pc class ra1 ra2 rdst regwrite count | H not-ready mask | G | B reg data | F
# E pc lane is_slot rd1 rd2 count | hex numbers, count repeats with pc+4 and lanes alternating
T dual_issue
H ffffffff
U 10 0 1 2 a 1 4
G
E 10 0 0 01010101 02020202 4
T pair_hazards
H ffffffff
U 100 0 1 2 5 1 1
U 104 5 5 0 0 0 1
U 108 3 0 0 7 1 1
U 10c 1 7 3 0 0 1
U 110 1 4 6 0 0 1
G
E 100 0 0 01010101 02020202 1
E 104 0 0 05050505 00000000 1
E 108 0 0 00000000 00000000 1
E 10c 0 0 07070707 03030303 1
E 110 0 0 04040404 06060606 1
T delay_slot
H ffffffff
U 200 2 1 2 1f 1 1
U 204 0 1f 3 8 1 1
G
E 200 0 0 01010101 02020202 1
E 204 1 1 1f1f1f1f 03030303 1
H 00000200
U 208 2 1 2 0 0 1
U 20c 0 9 4 8 1 1
G
E 208 0 0 01010101 02020202 1
E 20c 1 1 09090909 04040404 1
T operand_bypass
B 6 cafef00d
H ffffffff
U 300 0 6 7 8 1 1
U 304 0 7 6 9 1 1
G
E 300 0 0 cafef00d 07070707 1
E 304 1 0 07070707 cafef00d 1
T credits_flush
H ffffffff
U 400 0 1 2 a 1 1e
G
E 400 0 0 01010101 02020202 1e
H ffffffff
U 500 0 1 2 a 1 4
F
U 600 0 3 4 b 1 2
G
E 600 0 0 03030303 04040404 2

/* tb/issue_tb.sv */
`include "issue_macros.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int MAX_REC = 96;

    // one golden line, fields a..g in file column order
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        logic [31:0] g;
    } rec_t;

    // one lane expected on out_uop
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] lane;
        logic [31:0] slot;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [7:0]  test;
    } exp_t;

    logic                              clk;
    logic                              rst;
    logic                              flush;
    uop_t      [`ISSUE_LANES-1:0]      in_uop;
    logic      [1:0]                   credit_return;
    reg_addr_t [2*`ISSUE_LANES-1:0]    rs_addr;
    word_t     [2*`ISSUE_LANES-1:0]    rf_data;
    src_t      [2*`ISSUE_LANES-1:0]    src;
    issued_t   [`ISSUE_LANES-1:0]      out_uop;

    rec_t        rec [MAX_REC];
    exp_t        exp_q [$];
    uop_t        sent_uop [logic [31:0]];
    string       test_name [16];
    int          n_rec;
    int          n_test;
    int          cur_test;
    int          checked;
    int          e_seen;
    int          credits;
    logic        loaded;
    logic [31:0] hold_mask;
    logic [31:0] byp_valid;
    word_t       byp_data [32];
    logic [31:0] rng;

    issue_top dut (
        .clk, .rst, .flush, .in_uop, .credit_return,
        .rs_addr, .rf_data, .src, .out_uop
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // register file returns reg times 0x01010101, bypass and hold per register
    always_comb begin
        for (int i = 0; i < 2*`ISSUE_LANES; i++) begin
            rf_data[i]   = word_t'(rs_addr[i]) * 32'h01010101;
            src[i].ready = !hold_mask[rs_addr[i]];
            src[i].hit   = byp_valid[rs_addr[i]];
            src[i].data  = byp_data[rs_addr[i]];
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // copy k of a U record, pc steps by 4
    function automatic uop_t make_uop(input rec_t r, input int k);
        uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.pc       = r.a + 32'(4 * k);
        u.op_class = op_class_t'(r.b[2:0]);
        u.ra1      = reg_addr_t'(r.c);
        u.ra2      = reg_addr_t'(r.d);
        u.rdst     = reg_addr_t'(r.e);
        u.regwrite = r.f[0];
        return u;
    endfunction

    // decoded fields side by side for one compare
    function automatic logic [31:0] uop_fields(input uop_t u);
        return 32'({u.op_class, u.ra1, u.ra2, u.rdst, u.regwrite});
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %08h actual %08h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one cycle, credits returned in this cycle go back to the pool
    task automatic step();
        @(negedge clk);
        credits = credits + int'(credit_return);
        @(posedge clk);
        #1;
    endtask

    task automatic load_golden();
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [8*24-1:0]   word;
        logic [8*128-1:0]  line;
        rec_t              r;
        exp_t              x;
        fd = $fopen("tb/issue_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file tb/issue_golden.txt");
            $display("RESULT: FAIL");
            $fatal(1, "golden file missing");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            r      = '0;
            r.kind = kind;
            case (kind)
                "#": code = $fgets(line, fd);
                "T": begin
                    code = $fscanf(fd, "%s", word);
                    test_name[n_test] = $sformatf("%0s", word);
                    r.a = 32'(n_test);
                    n_test++;
                end
                "U": code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                    r.a, r.b, r.c, r.d, r.e, r.f, r.g);
                "H": code = $fscanf(fd, "%h", r.a);
                "B": code = $fscanf(fd, "%h %h", r.a, r.b);
                "G", "F": code = 0;
                "E": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", r.a, r.b, r.c, r.d, r.e, r.f);
                    // repeats alternate lanes, as a run of pairs does
                    for (int k = 0; k < int'(r.f); k++) begin
                        x.pc   = r.a + 32'(4 * k);
                        x.lane = r.b ^ 32'(k % 2);
                        x.slot = r.c;
                        x.rd1  = r.d;
                        x.rd2  = r.e;
                        x.test = 8'(n_test - 1);
                        exp_q.push_back(x);
                    end
                end
                default: begin
                    $display("unknown record kind %c in the golden file", kind);
                    $display("RESULT: FAIL");
                    $fatal(1, "bad golden file");
                end
            endcase
            if (kind != "#") begin
                rec[n_rec] = r;
                n_rec++;
            end
        end
        $fclose(fd);
    endtask

    // wait for all expected lanes so far, optionally all credits home
    task automatic drain(input logic credits_home);
        while (checked < e_seen) begin
            step();
        end
        repeat (2) step();
        if (credits_home) begin
            check_value({test_name[cur_test], " credits"}, `ISSUE_CREDITS, 32'(credits));
        end
    endtask

    // sender side, one or two lanes per cycle within credits, random gaps
    task automatic send_ops(input rec_t r);
        int k;
        int n;
        k = 0;
        while (k < int'(r.g)) begin
            rng = xorshift(rng);
            n   = (rng[8] && (k + 1 < int'(r.g))) ? 2 : 1;
            while (credits < n) begin
                step();
            end
            in_uop[0] = make_uop(r, k);
            sent_uop[in_uop[0].pc] = in_uop[0];
            if (n == 2) begin
                in_uop[1] = make_uop(r, k + 1);
                sent_uop[in_uop[1].pc] = in_uop[1];
            end
            credits = credits - n;
            step();
            in_uop = '0;
            k      = k + n;
            repeat (int'(rng[7:0]) % 3) step();
        end
    endtask

    task automatic run_record(input rec_t r);
        logic [31:0] held;
        case (r.kind)
            "T": begin
                drain(1'b1);
                byp_valid = '0;
                cur_test  = int'(r.a);
                $display("test %s", test_name[cur_test]);
            end
            "U": send_ops(r);
            "H": begin
                drain(1'b0);
                hold_mask = r.a;
                step();
            end
            // held ops sit a few cycles before release
            "G": begin
                repeat (4) step();
                hold_mask = '0;
                step();
            end
            "B": begin
                byp_valid[r.a[4:0]] = 1'b1;
                byp_data[r.a[4:0]]  = r.b;
            end
            "F": begin
                drain(1'b0);
                // head pair turns ready in the flush cycle and must still be dropped
                held      = hold_mask;
                hold_mask = '0;
                flush     = 1'b1;
                step();
                flush     = 1'b0;
                hold_mask = held;
                credits   = `ISSUE_CREDITS;
                check_value({test_name[cur_test], " credit_return"}, 0, 32'(credit_return));
            end
            "E": e_seen = e_seen + int'(r.f);
            default: ;
        endcase
    endtask

    // issued lanes in order against the expected list
    always @(negedge clk) begin
        exp_t  x;
        string tag;
        if (!rst) begin
            for (int l = 0; l < `ISSUE_LANES; l++) begin
                if (out_uop[l].uop.valid) begin
                    if (exp_q.size() == 0) begin
                        $display("lane %0d issued pc %08h but no issue was expected",
                                 l, out_uop[l].uop.pc);
                        $display("RESULT: FAIL");
                        $fatal(1, "unexpected issue");
                    end else begin
                        x   = exp_q.pop_front();
                        tag = test_name[x.test];
                        check_value({tag, " pc"}, x.pc, out_uop[l].uop.pc);
                        check_value({tag, " fields"}, uop_fields(sent_uop[x.pc]),
                                    uop_fields(out_uop[l].uop));
                        check_value({tag, " lane"}, x.lane, 32'(l));
                        check_value({tag, " is_slot"}, x.slot, 32'(out_uop[l].is_slot));
                        check_value({tag, " rd1"}, x.rd1, out_uop[l].rd1);
                        check_value({tag, " rd2"}, x.rd2, out_uop[l].rd2);
                        checked++;
                    end
                end
            end
        end
    end

    // watchdog, sized by the golden file
    initial begin
        wait (loaded);
        repeat (200 + 20 * n_rec) @(posedge clk);
        $display("timeout, %0d of %0d expected issues seen", checked, e_seen);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        in_uop    = '0;
        hold_mask = '0;
        byp_valid = '0;
        for (int i = 0; i < 32; i++) begin
            byp_data[i] = '0;
        end
        rng      = 32'h5b80f1f8;
        loaded   = 1'b0;
        n_rec    = 0;
        n_test   = 0;
        cur_test = 0;
        checked  = 0;
        e_seen   = 0;
        credits  = `ISSUE_CREDITS;
        load_golden();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_rec; i++) begin
            run_record(rec[i]);
        end
        drain(1'b1);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
